// File: Makefile
# Verilator build and run of the memory interface testbench

TOP := tb_tfacc_memif

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// File: list.f
src/memif_pkg.sv
src/memif_fill_if.sv
src/memif_regs.sv
src/rd_cache.sv
src/axi_burst_reader.sv
src/tfacc_memif.sv
tb/tb_tfacc_memif.sv

// File: src/axi_burst_reader.sv
//**********************************************************************
// AXI read master. Each fill request becomes one INCR burst of 8 byte
// beats, the accepted beats go back to the cache one per cycle.
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module axi_burst_reader
  import memif_pkg::*;
(
  input  wire         cclk,
  input  wire         reset,

  memif_fill_if.reader fill,

  output axi_addr_t   araddr,   // ar channel
  output logic [7:0]  arlen,
  output logic        arvalid,
  input  wire         arready,

  input  wire u64_t   rdata,    // r channel
  input  wire         rlast,
  input  wire         rvalid,
  output logic        rready
);

  burst_state_t state;
  logic         take;           // beat accepted this cycle

  assign arlen   = ARLEN_VAL;   // fixed line length
  assign arvalid = (state == bs_addr);
  assign rready  = (state == bs_data);
  assign take    = rready && rvalid;

  always_ff @(posedge cclk) begin
    if (reset) begin
      state <= bs_idle;
    end else begin
      case (state)
        bs_idle: begin
          if (fill.req) state <= bs_addr;
        end
        bs_addr: begin
          if (arready) state <= bs_data;   // address taken
        end
        bs_data: begin
          if (take && rlast) state <= bs_idle;
        end
        default: state <= bs_idle;
      endcase
    end
  end

  // latch the line address with the request
  always_ff @(posedge cclk) begin
    if (state == bs_idle && fill.req) araddr <= fill.line_adr;
  end

  // beats forwarded one cycle late
  always_ff @(posedge cclk) begin
    if (reset) begin
      fill.beat_valid <= 1'b0;
      fill.beat_last  <= 1'b0;
    end else begin
      fill.beat_valid <= take;
      fill.beat_last  <= take && rlast;
    end
  end

  always_ff @(posedge cclk) begin
    if (take) fill.beat_data <= rdata;
  end

endmodule

`default_nettype wire

// File: src/memif_fill_if.sv
//**********************************************************************
// Line fill channel between the read cache and the AXI burst reader.
// The cache takes modport cache, the reader takes modport reader.
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

interface memif_fill_if
  import memif_pkg::*;
  ();

  logic      req;         // one cycle strobe, reader must be idle
  axi_addr_t line_adr;    // held from req until the last beat
  logic      beat_valid;  // no back-pressure, every beat is taken
  u64_t      beat_data;   // beats come in address order
  logic      beat_last;

  modport cache (
    output req, line_adr,
    input  beat_valid, beat_data, beat_last
  );

  modport reader (
    input  req, line_adr,
    output beat_valid, beat_data, beat_last
  );

endinterface

`default_nettype wire

// File: src/memif_pkg.sv
//**********************************************************************
// Shared widths, CPU register map and AXI burst constants for the
// memory interface. Import it into the modules that use it.
//**********************************************************************
`default_nettype none

package memif_pkg;

  // vector types
  typedef logic [31:0] u32_t;       // bus addr/data, offsets, cache words
  typedef logic [63:0] u64_t;       // one axi beat, one stored line word
  typedef logic [39:0] axi_addr_t;  // axi read address

  // control block on the cpu bus
  localparam u32_t       REG_BLOCK = 32'hffff0180;
  localparam u32_t       REG_MASK  = 32'hffffffe0;  // 32 byte block match
  localparam logic [2:0] REG_CTRL  = 3'd0;          // clear request lives here
  localparam logic [2:0] REG_BASE  = 3'd1;          // base added to offsets
  localparam int         CLR_BIT   = 24;            // lane 3, lowest bit

  // burst geometry
  localparam int         BEAT_BYTES = 8;
  localparam int         BURST_LEN  = 4;            // beats per line
  localparam int         LINE_BYTES = 32;
  localparam logic [7:0] ARLEN_VAL  = 8'(BURST_LEN - 1);

  // burst reader fsm
  typedef enum logic [1:0] {
    bs_idle,   // waiting for a fill request
    bs_addr,   // arvalid up, waiting for arready
    bs_data    // taking beats until rlast
  } burst_state_t;

  // cache fsm
  typedef enum logic [1:0] {
    cs_idle,   // no request
    cs_lookup, // tag compare on the latched offset
    cs_fill    // line fill in flight
  } cache_state_t;

endpackage

`default_nettype wire

// File: src/memif_regs.sv
//**********************************************************************
// CPU bus decode of the 32 byte control block. Holds the base register,
// pulses the cache clear and returns registered readback with rdy.
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module memif_regs
  import memif_pkg::*;
(
  input  wire        cclk,
  input  wire        reset,

  input  wire u32_t  adr,   // cpu bus
  input  wire [3:0]  we,    // byte lane enables
  input  wire        re,
  input  wire u32_t  dw,
  output u32_t       dr,
  output logic       rdy,

  output u32_t       base,  // to the cache
  output logic       clr    // one cycle clear strobe
);

  logic       cs;    // block select
  logic [2:0] sel;   // register within the block

  assign cs  = (adr & REG_MASK) == REG_BLOCK;
  assign sel = adr[4:2];

  // clear bit only counts when lane 3 is written
  assign clr = cs && (sel == REG_CTRL) && we[3] && dw[CLR_BIT];

  // base register, byte lanes written separately
  always_ff @(posedge cclk) begin
    if (reset) begin
      base <= '0;
    end else if (cs && (sel == REG_BASE)) begin
      for (int i = 0; i < 4; i++) begin
        if (we[i]) base[8*i +: 8] <= dw[8*i +: 8];  // lane i only
      end
    end
  end

  // rdy follows any access by one cycle
  always_ff @(posedge cclk) begin
    if (reset) begin
      rdy <= 1'b0;
    end else begin
      rdy <= re | (|we);  // writes are acked too
    end
  end

  // readback data, only base is visible
  always_ff @(posedge cclk) begin
    if (re && cs && (sel == REG_BASE)) begin
      dr <= base;
    end else begin
      dr <= '0;         // ctrl and outside block read zero
    end
  end

endmodule

`default_nettype wire

// File: src/rd_cache.sv
//**********************************************************************
// Direct mapped read cache of NK lines of 32 bytes. Hits answer one
// cycle after c_re, misses fill the line over the fill channel first.
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module rd_cache
  import memif_pkg::*;
#(
  parameter int NK = 8              // lines, power of two
) (
  input  wire        cclk,
  input  wire        reset,

  input  wire u32_t  c_adr,         // byte offset from base
  input  wire        c_re,
  output logic       c_rdy,
  output u32_t       c_dr,

  input  wire u32_t  base,
  input  wire        clr,           // drop every line

  memif_fill_if.cache fill
);

  localparam int BEAT_LSB = $clog2(BEAT_BYTES);  // 3
  localparam int LINE_LSB = $clog2(LINE_BYTES);  // 5
  localparam int BCNT_W   = $clog2(BURST_LEN);   // beat index bits
  localparam int IDX_W    = $clog2(NK);
  localparam int TAG_W    = 32 - LINE_LSB - IDX_W;

  cache_state_t      state;
  u32_t              r_adr;         // latched request offset
  logic [BCNT_W-1:0] beat_cnt;      // next beat slot in the fill
  logic              clr_seen;      // clear hit while filling
  logic              fill_done;     // one cycle after beat_last

  logic [NK-1:0]     valid;
  logic [TAG_W-1:0]  tag_mem  [NK];
  u64_t              data_mem [NK][BURST_LEN];

  logic [IDX_W-1:0]  r_idx;
  logic [TAG_W-1:0]  r_tag;
  logic [BCNT_W-1:0] r_beat;
  u64_t              rd_beat;
  logic              hit;
  logic              hit_rdy;
  logic              accept;        // take a new c_re this cycle
  logic              last_beat;

  // split the latched offset
  assign r_idx  = r_adr[LINE_LSB +: IDX_W];
  assign r_tag  = r_adr[31 -: TAG_W];
  assign r_beat = r_adr[BEAT_LSB +: BCNT_W];

  assign hit     = valid[r_idx] && (tag_mem[r_idx] == r_tag);
  assign hit_rdy = (state == cs_lookup) && hit;
  assign accept  = c_re && ((state == cs_idle) || hit_rdy);

  assign last_beat = (state == cs_fill) && fill.beat_valid && fill.beat_last;

  // word select, low half holds the lower address
  assign rd_beat = data_mem[r_idx][r_beat];
  assign c_dr    = r_adr[BEAT_LSB-1] ? rd_beat[63:32] : rd_beat[31:0];
  assign c_rdy   = hit_rdy | fill_done;

  always_ff @(posedge cclk) begin
    if (accept) r_adr <= c_adr;
  end

  // main fsm
  always_ff @(posedge cclk) begin
    if (reset) begin
      state     <= cs_idle;
      fill.req  <= 1'b0;
      fill_done <= 1'b0;
      clr_seen  <= 1'b0;
      beat_cnt  <= '0;
    end else begin
      fill.req  <= 1'b0;            // strobe
      fill_done <= 1'b0;
      case (state)
        cs_idle: begin
          if (c_re) state <= cs_lookup;
        end
        cs_lookup: begin
          if (!hit) begin           // miss, start the fill
            fill.req <= 1'b1;
            beat_cnt <= '0;
            clr_seen <= 1'b0;
            state    <= cs_fill;
          end else if (!c_re) begin
            state <= cs_idle;       // back to back hits stay here
          end
        end
        cs_fill: begin
          if (clr) clr_seen <= 1'b1;
          if (fill.beat_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (fill.beat_last) begin
              fill_done <= 1'b1;    // c_rdy next cycle
              state     <= cs_idle;
            end
          end
        end
        default: state <= cs_idle;
      endcase
    end
  end

  // fill address, base plus line aligned offset
  always_ff @(posedge cclk) begin
    if (state == cs_lookup && !hit) begin
      fill.line_adr <= axi_addr_t'(base + {r_adr[31:LINE_LSB], {LINE_LSB{1'b0}}});
    end
  end

  // line storage
  always_ff @(posedge cclk) begin
    if (state == cs_fill && fill.beat_valid) begin
      data_mem[r_idx][beat_cnt] <= fill.beat_data;
    end
    if (last_beat) tag_mem[r_idx] <= r_tag;
  end

  // valid bits, a clear during the fill keeps that line invalid
  always_ff @(posedge cclk) begin
    if (reset) begin
      valid <= '0;
    end else if (clr) begin
      valid <= '0;
    end else if (last_beat && !clr_seen) begin
      valid[r_idx] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/tfacc_memif.sv
//**********************************************************************
// Memory interface top. Wires the register decode, the read cache and
// the AXI burst reader to the CPU bus, cache port and AXI read ports.
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tfacc_memif
  import memif_pkg::*;
#(
  parameter int NK = 8            // cache lines
) (
  input  wire         cclk,
  input  wire         reset,

  input  wire u32_t   adr,        // cpu bus
  input  wire [3:0]   we,
  input  wire         re,
  input  wire u32_t   dw,
  output u32_t        dr,
  output logic        rdy,

  input  wire u32_t   c_adr,      // accelerator read port
  input  wire         c_re,
  output logic        c_rdy,
  output u32_t        c_dr,

  output axi_addr_t   araddr,     // axi read channel
  output logic [7:0]  arlen,
  output logic        arvalid,
  input  wire         arready,
  input  wire u64_t   rdata,
  input  wire         rlast,
  input  wire         rvalid,
  output logic        rready
);

  u32_t base;   // request base address
  logic clr;    // cache clear strobe

  memif_fill_if u_fill ();

  memif_regs u_regs (
    .cclk  (cclk),
    .reset (reset),
    .adr   (adr),
    .we    (we),
    .re    (re),
    .dw    (dw),
    .dr    (dr),
    .rdy   (rdy),
    .base  (base),
    .clr   (clr)
  );

  rd_cache #(
    .NK (NK)
  ) u_cache (
    .cclk  (cclk),
    .reset (reset),
    .c_adr (c_adr),
    .c_re  (c_re),
    .c_rdy (c_rdy),
    .c_dr  (c_dr),
    .base  (base),
    .clr   (clr),
    .fill  (u_fill.cache)
  );

  axi_burst_reader u_reader (
    .cclk    (cclk),
    .reset   (reset),
    .fill    (u_fill.reader),
    .araddr  (araddr),
    .arlen   (arlen),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rlast   (rlast),
    .rvalid  (rvalid),
    .rready  (rready)
  );

endmodule

`default_nettype wire

// File: tb/tb_tfacc_memif.sv
//**********************************************************************
// Testbench for the memory interface top. An AXI memory model with random
// stalls, a shadow of the cache tags, and checks on every read.
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_tfacc_memif
  import memif_pkg::*;
  ();

  localparam int   NK         = 8;
  localparam int   IDX_BITS   = 3;                 // log2 NK
  localparam int   LINE_SHIFT = 5;                 // 32 byte lines
  localparam int   MAX_CYCLES = 4000;              // ~60 requests at 40 cycles worst
  localparam int   RD_WAIT    = 200;               // per request handshake limit
  localparam u32_t CTRL_ADR   = REG_BLOCK;
  localparam u32_t BASE_ADR   = REG_BLOCK + 32'd4;

  logic      cclk;
  logic      reset;
  u32_t      adr;
  logic [3:0] we;
  logic      re;
  u32_t      dw;
  u32_t      dr;
  logic      rdy;
  u32_t      c_adr;
  logic      c_re;
  logic      c_rdy;
  u32_t      c_dr;
  axi_addr_t araddr;
  logic [7:0] arlen;
  logic      arvalid;
  logic      arready;
  u64_t      rdata;
  logic      rlast;
  logic      rvalid;
  logic      rready;

  integer    seed;
  int        cycles = 0;
  int        errors = 0;
  int        checks = 0;
  int        test_no = 1;
  int        test_err0 = 0;
  int        ar_count = 0;       // AR handshakes seen
  axi_addr_t last_araddr;
  logic [7:0] last_arlen;
  u32_t      base_val;           // base the tests expect
  logic      sh_valid [NK];      // shadow of the cache state
  u32_t      sh_tag [NK];

  tfacc_memif #(.NK(NK)) dut (
    .cclk(cclk), .reset(reset),
    .adr(adr), .we(we), .re(re), .dw(dw), .dr(dr), .rdy(rdy),
    .c_adr(c_adr), .c_re(c_re), .c_rdy(c_rdy), .c_dr(c_dr),
    .araddr(araddr), .arlen(arlen), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready)
  );

  initial begin
    cclk = 1'b0;
    forever #4 cclk = ~cclk;     // 8 ns period
  end

  always @(posedge cclk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // word at byte address B is B xor 5a5a0000
  function automatic u32_t mem_word(input u32_t b);
    return b ^ 32'h5a5a0000;
  endfunction

  function automatic u64_t make_beat(input u32_t a);
    return {mem_word(a + 32'd4), mem_word(a)};  // low half is the lower word
  endfunction

  // expected c_dr is the word at base plus offset aligned down to 4
  function automatic u32_t ref_word(input u32_t b, input u32_t off);
    return (b + (off & ~32'd3)) ^ 32'h5a5a0000;
  endfunction

  always @(negedge cclk) begin
    if (arvalid === 1'b1 && arready === 1'b1) begin
      ar_count    = ar_count + 1;
      last_araddr = araddr;      // address of the latest burst
      last_arlen  = arlen;
    end
  end

  // AXI slave with random arready delay and rvalid gaps
  initial begin : axi_mem
    axi_addr_t ar_adr;
    int        stall;
    wait (reset === 1'b0);
    forever begin
      @(negedge cclk);
      if (arvalid === 1'b1) begin
        ar_adr = araddr;
        stall  = {$random(seed)} % 8;
        repeat (stall) @(posedge cclk);
        @(posedge cclk);
        arready <= 1'b1;
        @(posedge cclk);
        arready <= 1'b0;         // handshake on this edge
        for (int b = 0; b < BURST_LEN; b++) begin
          stall = {$random(seed)} % 4;
          repeat (stall) @(posedge cclk);
          @(posedge cclk);
          rvalid <= 1'b1;
          rdata  <= make_beat(ar_adr[31:0] + 32'(BEAT_BYTES * b));
          rlast  <= (b == BURST_LEN - 1);
          @(negedge cclk);
          while (rready !== 1'b1) @(negedge cclk);
          @(posedge cclk);
          rvalid <= 1'b0;        // beat taken here
          rlast  <= 1'b0;
        end
      end
    end
  end

  task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    $display("test %0d %s: %0d errors", test_no, name, errors - test_err0);
    test_no++;
    test_err0 = errors;
  endtask

  task automatic reg_read(input u32_t a, output u32_t data);
    @(posedge cclk);
    adr <= a;
    re  <= 1'b1;
    @(posedge cclk);
    re  <= 1'b0;
    @(negedge cclk);
    compare("rdy one cycle after re", 64'(rdy), 64'd1);
    data = dr;
  endtask

  task automatic reg_write(input u32_t a, input logic [3:0] lanes, input u32_t data);
    @(posedge cclk);
    adr <= a;
    we  <= lanes;
    dw  <= data;
    @(posedge cclk);
    we  <= 4'h0;
    @(negedge cclk);
    compare("rdy one cycle after we", 64'(rdy), 64'd1);
  endtask

  task automatic fetch_word(input u32_t off, output u32_t data, output int lat);
    lat = 0;
    @(posedge cclk);
    c_adr <= off;
    c_re  <= 1'b1;
    @(posedge cclk);
    c_re  <= 1'b0;
    do begin
      @(negedge cclk);
      lat++;
    end while (c_rdy !== 1'b1 && lat < RD_WAIT);
    if (c_rdy !== 1'b1) begin
      $display("error: no c_rdy within %0d cycles for offset %h", RD_WAIT, off);
      errors++;
    end
    data = c_dr;
  endtask

  task automatic clear_shadow();
    for (int i = 0; i < NK; i++) sh_valid[i] = 1'b0;
  endtask

  // one read with the miss predicted from the shadow tags
  task automatic verify_read(input u32_t off);
    u32_t got;
    int   lat;
    int   ar_before;
    int   idx;
    u32_t tag;
    logic miss;
    idx       = int'(off[LINE_SHIFT +: IDX_BITS]);
    tag       = off >> (LINE_SHIFT + IDX_BITS);
    miss      = !(sh_valid[idx] && sh_tag[idx] == tag);
    ar_before = ar_count;
    fetch_word(off, got, lat);
    compare($sformatf("c_dr at offset %h", off), 64'(got), 64'(ref_word(base_val, off)));
    compare($sformatf("bursts for offset %h", off), 64'(ar_count - ar_before),
            miss ? 64'd1 : 64'd0);
    if (miss) begin
      compare("araddr", 64'(last_araddr), 64'(base_val + (off & ~32'd31)));
      compare("arlen", 64'(last_arlen), 64'd3);
      sh_valid[idx] = 1'b1;
      sh_tag[idx]   = tag;
    end else begin
      compare("hit latency", 64'(lat), 64'd1);
    end
  endtask

  initial begin : tests
    u32_t rd;
    int   ar_start;
    seed = 32'h05ff2d56;
    reset   <= 1'b1;
    adr     <= '0;
    we      <= 4'h0;
    re      <= 1'b0;
    dw      <= '0;
    c_adr   <= '0;
    c_re    <= 1'b0;
    arready <= 1'b0;
    rdata   <= '0;
    rlast   <= 1'b0;
    rvalid  <= 1'b0;
    base_val = '0;
    clear_shadow();
    repeat (2) @(posedge cclk);
    reset <= 1'b0;

    @(negedge cclk);
    compare("rdy after reset", 64'(rdy), 64'd0);
    compare("c_rdy after reset", 64'(c_rdy), 64'd0);
    compare("arvalid after reset", 64'(arvalid), 64'd0);
    reg_read(BASE_ADR, rd);
    compare("base after reset", 64'(rd), 64'd0);
    report_test("reset state");

    reg_write(BASE_ADR, 4'hf, 32'h12345678);
    reg_read(BASE_ADR, rd);
    compare("base full write", 64'(rd), 64'h12345678);
    reg_write(BASE_ADR, 4'b0101, 32'haabbccdd);  // lanes 0 and 2 only
    reg_read(BASE_ADR, rd);
    compare("base lane write", 64'(rd), 64'h12bb56dd);
    reg_read(REG_BLOCK + 32'h24, rd);            // base slot of the next block
    compare("read outside block", 64'(rd), 64'd0);
    reg_read(CTRL_ADR, rd);
    compare("read ctrl", 64'(rd), 64'd0);
    base_val = 32'h00040000;
    reg_write(BASE_ADR, 4'hf, base_val);
    report_test("base register");

    verify_read(32'h00000014);
    compare("first miss burst count", 64'(ar_count), 64'd1);
    report_test("first miss");

    ar_start = ar_count;
    for (int w = 0; w < 8; w++) verify_read(32'(4 * w));
    compare("no bursts on hits", 64'(ar_count - ar_start), 64'd0);
    report_test("line hits");

    reg_write(CTRL_ADR, 4'b1000, 32'h01000000);  // clear via lane 3
    clear_shadow();
    ar_start = ar_count;
    verify_read(32'h00000014);
    compare("burst after clear", 64'(ar_count - ar_start), 64'd1);
    report_test("cache clear");

    verify_read(32'h00000040);
    verify_read(32'h00000140);                   // same index with a new tag
    verify_read(32'h00000044);
    for (int n = 0; n < 40; n++) begin
      rd = (32'({$random(seed)} % 4) << 8) | (32'({$random(seed)} % 8) << 5)
         | (32'({$random(seed)} % 8) << 2);
      verify_read(rd);
    end
    report_test("random reads");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
